// File: all.f
verilog/daq_pkg.sv
verilog/spi_master.sv
verilog/spi_3wire_bridge.sv
verilog/gpio_bank.sv
verilog/daq_ctrl_top.sv
testbench/tb_checker.sv
testbench/tb_daq_ctrl.sv

// File: Makefile
# Verilator build and run for the converter board control block

all: run

compile:
	verilator --binary --timing -f all.f --top-module tb_daq_ctrl -Mdir obj_dir -o sim

run: compile
	./obj_dir/sim | tee sim.log
	grep -q "^TESTS PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all compile run clean

// File: testbench/tb_daq_ctrl.sv
/*
 * Testbench for the converter board control block.
 * Drives SPI transactions into a three-wire device model with one
 * register file per chip select, then GPIO writes and status changes.
 */

`default_nettype none

module tb_daq_ctrl import daq_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int          SCLK_DIV    = 4;
  localparam int          SYNC_STAGES = 2;
  // Register reset offsets, {ADC, DAC, clock chip}
  localparam logic [23:0] DEV_OFS     = 24'h5a_a5_3c;
  localparam int          TIMEOUT     = 1000;
  localparam logic [31:0] SEED        = 32'h94d5_6ad1;

  logic                   clk = 1'b0;
  logic                   rst_n = 1'b0;
  logic                   spi_start = 1'b0;
  cs_sel_e                spi_cs = CS_CLK;
  logic                   spi_read = 1'b0;
  logic [SPI_ADDR_W-1:0]  spi_addr = '0;
  logic [SPI_DATA_W-1:0]  spi_wdata = '0;
  logic                   sdio_i = 1'b0;
  logic                   gpio_wr = 1'b0;
  logic [GPIO_CTRL_W-1:0] gpio_wdata = '0;
  logic [GPIO_BD_W-1:0]   gpio_bd = '0;
  logic                   trig = 1'b0;
  logic                   adc_fdb = 1'b0;
  logic                   adc_fda = 1'b0;
  logic                   dac_irq = 1'b0;
  logic [1:0]             clkd_status = '0;

  logic                   spi_busy;
  logic                   spi_done;
  logic [SPI_DATA_W-1:0]  spi_rdata;
  logic                   csn_clk;
  logic                   csn_dac;
  logic                   csn_adc;
  logic                   spi_clk;
  logic                   sdio_o;
  logic                   sdio_oe;
  logic                   spi_dir;
  logic [GPIO_CTRL_W-1:0] gpio_ctrl;
  logic [GPIO_STAT_W-1:0] gpio_stat;
  logic                   adc_pd;
  logic                   dac_txen;
  logic                   dac_reset;
  logic                   clkd_sync;
  logic [GPIO_LED_W-1:0]  gpio_bd_out;

  logic [31:0] lfsr = SEED;

  daq_ctrl_top #(
    .SCLK_DIV    (SCLK_DIV),
    .SYNC_STAGES (SYNC_STAGES)
  ) daq_ctrl_top_i (
    .clk_i         (clk),
    .rst_n_i       (rst_n),
    .spi_start_i   (spi_start),
    .spi_cs_i      (spi_cs),
    .spi_read_i    (spi_read),
    .spi_addr_i    (spi_addr),
    .spi_wdata_i   (spi_wdata),
    .spi_busy_o    (spi_busy),
    .spi_done_o    (spi_done),
    .spi_rdata_o   (spi_rdata),
    .spi_csn_clk_o (csn_clk),
    .spi_csn_dac_o (csn_dac),
    .spi_csn_adc_o (csn_adc),
    .spi_clk_o     (spi_clk),
    .sdio_o        (sdio_o),
    .sdio_oe_o     (sdio_oe),
    .sdio_i        (sdio_i),
    .spi_dir_o     (spi_dir),
    .gpio_wr_i     (gpio_wr),
    .gpio_wdata_i  (gpio_wdata),
    .gpio_ctrl_o   (gpio_ctrl),
    .gpio_stat_o   (gpio_stat),
    .gpio_bd_i     (gpio_bd),
    .trig_i        (trig),
    .adc_fdb_i     (adc_fdb),
    .adc_fda_i     (adc_fda),
    .dac_irq_i     (dac_irq),
    .clkd_status_i (clkd_status),
    .adc_pd_o      (adc_pd),
    .dac_txen_o    (dac_txen),
    .dac_reset_o   (dac_reset),
    .clkd_sync_o   (clkd_sync),
    .gpio_bd_o     (gpio_bd_out)
  );

  tb_checker #(
    .SCLK_DIV    (SCLK_DIV),
    .SYNC_STAGES (SYNC_STAGES),
    .DEV_OFS     (DEV_OFS)
  ) checker_i (
    .clk_i (clk), .rst_n_i (rst_n),
    .spi_start_i (spi_start), .spi_cs_i (spi_cs), .spi_read_i (spi_read),
    .spi_addr_i (spi_addr), .spi_wdata_i (spi_wdata), .spi_busy_i (spi_busy),
    .spi_done_i (spi_done), .spi_rdata_i (spi_rdata),
    .csn_i ({csn_adc, csn_dac, csn_clk}), .sclk_i (spi_clk),
    .sdio_oe_i (sdio_oe), .spi_dir_i (spi_dir),
    .gpio_wr_i (gpio_wr), .gpio_wdata_i (gpio_wdata), .gpio_ctrl_i (gpio_ctrl),
    .gpio_stat_i (gpio_stat), .bd_i (gpio_bd), .trig_i (trig),
    .adc_fdb_i (adc_fdb), .adc_fda_i (adc_fda), .dac_irq_i (dac_irq),
    .clkd_status_i (clkd_status), .adc_pd_i (adc_pd), .dac_txen_i (dac_txen),
    .dac_reset_i (dac_reset), .clkd_sync_i (clkd_sync), .led_i (gpio_bd_out)
  );

  initial begin
    forever #2 clk = ~clk;
  end

  // ****************************************
  // Three-wire device model
  // ****************************************

  logic [7:0]  dev_mem [int];
  logic [23:0] dev_sh = '0;
  int          dev_cnt = 0;
  int          dev_sel = 0;
  logic        dev_rd = 1'b0;
  logic [7:0]  dev_addr = '0;
  wire logic   csn_idle = csn_clk & csn_dac & csn_adc;

  function automatic logic [7:0] dev_byte(input int d, input logic [7:0] a);
    int key;
    key = d * 256 + int'(a);
    if (dev_mem.exists(key)) begin
      return dev_mem[key];
    end
    return a ^ 8'(DEV_OFS >> (8 * d));
  endfunction

  // Instruction bits are taken on rising edges, the read bit comes first
  always @(posedge spi_clk or posedge csn_idle) begin
    if (csn_idle) begin
      dev_cnt <= 0;
      dev_rd  <= 1'b0;
    end else begin
      dev_sh  <= {dev_sh[22:0], sdio_o};
      dev_cnt <= dev_cnt + 1;
      if (dev_cnt == 15) begin
        dev_rd   <= dev_sh[14];
        dev_addr <= {dev_sh[6:0], sdio_o};
        dev_sel  <= !csn_clk ? 0 : (!csn_dac ? 1 : 2);
      end
      if ((dev_cnt == 23) && !dev_rd) begin
        dev_mem[dev_sel * 256 + int'(dev_addr)] = {dev_sh[6:0], sdio_o};
      end
    end
  end

  // Read data leaves MSB first on the falling edges of the data phase
  always @(negedge spi_clk) begin
    logic [7:0] b;
    b = dev_byte(dev_sel, dev_addr) << (dev_cnt - 16);
    if (dev_rd && (dev_cnt >= 16) && (dev_cnt <= 23)) begin
      sdio_i <= b[7];
    end else begin
      sdio_i <= 1'b0;
    end
  end

  // ****************************************
  // Stimulus
  // ****************************************

  // Taps 32, 22, 2 and 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      val  = {val[30:0], lfsr[0]};
    end
  endtask

  task automatic report_test(input int idx, input string name);
    $display("test %0d %s: %0d checks, %0d errors", idx + 1, name,
             checker_i.chk_cnt[idx], checker_i.err_cnt[idx]);
  endtask

  task automatic spi_xfer(input cs_sel_e cs, input logic rd, input logic [14:0] addr,
                          input logic [7:0] wd, output logic ok);
    int t;
    @(posedge clk);
    spi_start <= 1'b1;
    spi_cs    <= cs;
    spi_read  <= rd;
    spi_addr  <= addr;
    spi_wdata <= wd;
    @(posedge clk);
    spi_start <= 1'b0;
    repeat (10) @(posedge clk);
    // A second start in the middle of the transfer must be dropped
    spi_start <= 1'b1;
    spi_cs    <= (cs == CS_CLK) ? CS_DAC : CS_CLK;
    spi_read  <= ~rd;
    spi_addr  <= ~addr;
    spi_wdata <= ~wd;
    @(posedge clk);
    spi_start <= 1'b0;
    t = 0;
    while (!spi_done && (t < TIMEOUT)) begin
      @(posedge clk);
      t++;
    end
    ok = spi_done;
    if (!ok) begin
      $display("Timeout: spi_done_o did not pulse within %0d cycles", TIMEOUT);
    end
  endtask

  initial begin
    logic [31:0] r;
    logic [31:0] a;
    logic [31:0] d;
    logic        ok;
    int          errs;
    int          chks;
    ok = 1'b1;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    repeat (4) @(posedge clk);
    report_test(0, "reset state");

    for (int i = 0; i < 30; i++) begin
      take_bits(3, r);
      take_bits(15, a);
      take_bits(8, d);
      // Address bits 7:4 cleared so reads often hit earlier writes
      if (ok) begin
        spi_xfer((r[1:0] == 2'd3) ? CS_ADC : cs_sel_e'(r[1:0]), r[2],
                 {a[14:8], 4'h0, a[3:0]}, d[7:0], ok);
      end
    end
    report_test(1, "write and read back");
    report_test(2, "direction turnaround");
    report_test(3, "transaction timing");

    if (ok) begin
      for (int i = 0; i < 20; i++) begin
        take_bits(GPIO_CTRL_W, r);
        @(posedge clk);
        gpio_wr    <= 1'b1;
        gpio_wdata <= r[GPIO_CTRL_W-1:0];
        @(posedge clk);
        gpio_wr    <= 1'b0;
      end
      @(posedge clk);
      for (int i = 0; i < 40; i++) begin
        take_bits(GPIO_STAT_W, r);
        @(posedge clk);
        {trig, adc_fdb, adc_fda, dac_irq, clkd_status, gpio_bd} <= r[GPIO_STAT_W-1:0];
      end
      repeat (SYNC_STAGES + 2) @(posedge clk);
    end
    report_test(4, "GPIO control");
    report_test(5, "status synchronization");

    errs = 0;
    chks = 0;
    for (int i = 0; i < 6; i++) begin
      errs += checker_i.err_cnt[i];
      chks += checker_i.chk_cnt[i];
    end
    $display("%0d checks, %0d errors", chks, errs);
    if (ok && (errs == 0)) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: testbench/tb_checker.sv
/*
 * Checker for the converter board control block.
 * Mirrors the device register files from the observed SPI starts and
 * compares read data, chip selects, line direction, transaction
 * latency, GPIO pins and synchronized status against expected values.
 */

`default_nettype none

module tb_checker import daq_pkg::*; #(
  parameter int          SCLK_DIV    = 4,
  parameter int          SYNC_STAGES = 2,
  parameter logic [23:0] DEV_OFS     = 24'h0
) (
  input wire logic                   clk_i,
  input wire logic                   rst_n_i,
  input wire logic                   spi_start_i,
  input wire cs_sel_e                spi_cs_i,
  input wire logic                   spi_read_i,
  input wire logic [SPI_ADDR_W-1:0]  spi_addr_i,
  input wire logic [SPI_DATA_W-1:0]  spi_wdata_i,
  input wire logic                   spi_busy_i,
  input wire logic                   spi_done_i,
  input wire logic [SPI_DATA_W-1:0]  spi_rdata_i,
  input wire logic [SPI_CS_W-1:0]    csn_i,
  input wire logic                   sclk_i,
  input wire logic                   sdio_oe_i,
  input wire logic                   spi_dir_i,
  input wire logic                   gpio_wr_i,
  input wire logic [GPIO_CTRL_W-1:0] gpio_wdata_i,
  input wire logic [GPIO_CTRL_W-1:0] gpio_ctrl_i,
  input wire logic [GPIO_STAT_W-1:0] gpio_stat_i,
  input wire logic [GPIO_BD_W-1:0]   bd_i,
  input wire logic                   trig_i,
  input wire logic                   adc_fdb_i,
  input wire logic                   adc_fda_i,
  input wire logic                   dac_irq_i,
  input wire logic [1:0]             clkd_status_i,
  input wire logic                   adc_pd_i,
  input wire logic                   dac_txen_i,
  input wire logic                   dac_reset_i,
  input wire logic                   clkd_sync_i,
  input wire logic [GPIO_LED_W-1:0]  led_i
);

  timeunit 1ns;
  timeprecision 100ps;

  // Check and error counts for each of the six tests
  int err_cnt [6];
  int chk_cnt [6];

  // Written registers are keyed by device * 256 + low address byte
  logic [7:0] ref_mem [int];

  logic                   started = 1'b0;
  logic                   xfer_on = 1'b0;
  cs_sel_e                cur_cs = CS_CLK;
  logic                   cur_read = 1'b0;
  logic [7:0]             cur_addr = '0;
  int                     cyc = 0;
  int                     rises = 0;
  logic                   sclk_d = 1'b0;
  logic                   gpio_pend = 1'b0;
  logic [GPIO_CTRL_W-1:0] gpio_exp = '0;
  logic [GPIO_STAT_W-1:0] stat_hist [SYNC_STAGES];
  int                     stat_fill = 0;

  // Expected register value is the last write or the address XOR the device offset
  function automatic logic [7:0] ref_byte(input cs_sel_e cs, input logic [7:0] a);
    int key;
    key = int'(cs) * 256 + int'(a);
    if (ref_mem.exists(key)) begin
      return ref_mem[key];
    end
    return a ^ 8'(DEV_OFS >> (8 * int'(cs)));
  endfunction

  task automatic check(input int t, input string sig, input logic [31:0] got,
                       input logic [31:0] exp);
    chk_cnt[t]++;
    if (got !== exp) begin
      err_cnt[t]++;
      $display("[ERROR] %0t ns: %s expected %h, got %h", $time, sig, exp, got);
    end
  endtask

  always @(posedge clk_i) begin
    logic [GPIO_STAT_W-1:0] stat_now;
    logic [SPI_CS_W-1:0]    exp_csn;
    logic                   exp_drive;
    stat_now = {trig_i, adc_fdb_i, adc_fda_i, dac_irq_i, clkd_status_i, bd_i};
    if (!rst_n_i) begin
      started   = 1'b0;
      xfer_on   = 1'b0;
      gpio_pend = 1'b0;
      rises     = 0;
    end else begin
      // ****************************************
      // Reset state on the first sample after reset
      // ****************************************
      if (!started) begin
        started = 1'b1;
        check(0, "spi_csn", 32'(csn_i), 32'h7);
        check(0, "spi_dir_o", 32'(spi_dir_i), 32'h1);
        check(0, "spi_busy_o", 32'(spi_busy_i), 32'h0);
        check(0, "gpio_ctrl_o", 32'(gpio_ctrl_i), 32'h0);
        check(0, "control pins", 32'({adc_pd_i, dac_txen_i, dac_reset_i, clkd_sync_i}), 32'h0);
      end

      // ****************************************
      // SPI transactions
      // ****************************************
      if (xfer_on) begin
        cyc++;
        if (spi_done_i) begin
          // The done pulse is seen one edge after the edge that sets it
          check(3, "spi_done_o latency", 32'(cyc - 1), 32'(2 + 2 * SCLK_DIV * SPI_WORD_W));
          if (cur_read) begin
            check(1, "spi_rdata_o", 32'(spi_rdata_i), 32'(ref_byte(cur_cs, cur_addr)));
          end
          xfer_on = 1'b0;
        end
      end
      // Pins are {ADC, DAC, clock chip}, only the selected one goes low
      case (cur_cs)
        CS_CLK:  exp_csn = 3'b110;
        CS_DAC:  exp_csn = 3'b101;
        default: exp_csn = 3'b011;
      endcase
      if (!spi_busy_i) begin
        check(1, "spi_csn idle", 32'(csn_i), 32'h7);
      end else if (csn_i != 3'h7) begin
        check(1, "spi_csn", 32'(csn_i), 32'(exp_csn));
      end

      // The device owns the line after 16 rising edges of a read
      exp_drive = (csn_i == 3'h7) || !(cur_read && (rises >= SPI_INSTR_W));
      check(2, "sdio_oe_o", 32'(sdio_oe_i), 32'(exp_drive));
      check(2, "spi_dir_o", 32'(spi_dir_i), 32'(exp_drive));
      if (csn_i == 3'h7) begin
        rises = 0;
      end else if (sclk_i && !sclk_d) begin
        rises++;
      end

      // A start is only taken while the master is idle
      if (spi_start_i && !spi_busy_i) begin
        xfer_on  = 1'b1;
        cyc      = 0;
        cur_cs   = spi_cs_i;
        cur_read = spi_read_i;
        cur_addr = spi_addr_i[7:0];
        if (!spi_read_i) begin
          ref_mem[int'(spi_cs_i) * 256 + int'(spi_addr_i[7:0])] = spi_wdata_i;
        end
      end

      // ****************************************
      // GPIO control and status
      // ****************************************
      if (gpio_pend) begin
        check(4, "gpio_ctrl_o", 32'(gpio_ctrl_i), 32'(gpio_exp));
        check(4, "adc_pd_o", 32'(adc_pd_i), 32'(gpio_exp[GPIO_ADC_PD]));
        check(4, "dac_txen_o", 32'(dac_txen_i), 32'(gpio_exp[GPIO_DAC_TXEN]));
        check(4, "dac_reset_o", 32'(dac_reset_i), 32'(gpio_exp[GPIO_DAC_RESET]));
        check(4, "clkd_sync_o", 32'(clkd_sync_i), 32'(gpio_exp[GPIO_CLKD_SYNC]));
        check(4, "gpio_bd_o", 32'(led_i), 32'(gpio_exp[GPIO_LED_W-1:0]));
      end
      gpio_pend = gpio_wr_i;
      if (gpio_wr_i) begin
        gpio_exp = gpio_wdata_i;
      end

      // Oldest history entry is the input from SYNC_STAGES samples ago
      if (stat_fill == SYNC_STAGES) begin
        check(5, "gpio_stat_o", 32'(gpio_stat_i), 32'(stat_hist[SYNC_STAGES-1]));
      end
    end
    for (int i = SYNC_STAGES - 1; i > 0; i--) begin
      stat_hist[i] = stat_hist[i-1];
    end
    stat_hist[0] = stat_now;
    if (stat_fill < SYNC_STAGES) begin
      stat_fill++;
    end
    sclk_d = sclk_i;
  end

endmodule

`default_nettype wire

// File: verilog/daq_ctrl_top.sv
/*
 * Control top level of the converter evaluation board.
 * Connects the SPI master, the three-wire adapter and the GPIO bank
 * to the board pins and the processor strobes.
 */

`default_nettype none

module daq_ctrl_top import daq_pkg::*; #(
  parameter int SCLK_DIV    = 4,
  parameter int SYNC_STAGES = 2
) (
  input  wire logic                   clk_i,
  input  wire logic                   rst_n_i,
  // Processor side of the SPI master
  input  wire logic                   spi_start_i,
  input  wire cs_sel_e                spi_cs_i,
  input  wire logic                   spi_read_i,
  input  wire logic [SPI_ADDR_W-1:0]  spi_addr_i,
  input  wire logic [SPI_DATA_W-1:0]  spi_wdata_i,
  output logic                        spi_busy_o,
  output logic                        spi_done_o,
  output logic      [SPI_DATA_W-1:0]  spi_rdata_o,
  // Three-wire SPI pins
  output logic                        spi_csn_clk_o,
  output logic                        spi_csn_dac_o,
  output logic                        spi_csn_adc_o,
  output logic                        spi_clk_o,
  output logic                        sdio_o,
  output logic                        sdio_oe_o,
  input  wire logic                   sdio_i,
  output logic                        spi_dir_o,
  // Processor side of the GPIO bank
  input  wire logic                   gpio_wr_i,
  input  wire logic [GPIO_CTRL_W-1:0] gpio_wdata_i,
  output logic      [GPIO_CTRL_W-1:0] gpio_ctrl_o,
  output logic      [GPIO_STAT_W-1:0] gpio_stat_o,
  // Board status and control pins
  input  wire logic [GPIO_BD_W-1:0]   gpio_bd_i,
  input  wire logic                   trig_i,
  input  wire logic                   adc_fdb_i,
  input  wire logic                   adc_fda_i,
  input  wire logic                   dac_irq_i,
  input  wire logic [1:0]             clkd_status_i,
  output logic                        adc_pd_o,
  output logic                        dac_txen_o,
  output logic                        dac_reset_o,
  output logic                        clkd_sync_o,
  output logic      [GPIO_LED_W-1:0]  gpio_bd_o
);

  logic [SPI_CS_W-1:0] spi_csn;
  logic                spi_mosi;
  logic                spi_miso;

  spi_master #(
    .SCLK_DIV (SCLK_DIV)
  ) spi_master_i (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .start_i    (spi_start_i),
    .cs_i       (spi_cs_i),
    .read_i     (spi_read_i),
    .addr_i     (spi_addr_i),
    .wdata_i    (spi_wdata_i),
    .busy_o     (spi_busy_o),
    .done_o     (spi_done_o),
    .rdata_o    (spi_rdata_o),
    .spi_csn_o  (spi_csn),
    .spi_sclk_o (spi_clk_o),
    .spi_mosi_o (spi_mosi),
    .spi_miso_i (spi_miso)
  );

  // The adapter listens to the same clock and chip selects as the pins
  spi_3wire_bridge spi_3wire_bridge_i (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .spi_csn_i  (spi_csn),
    .spi_sclk_i (spi_clk_o),
    .spi_mosi_i (spi_mosi),
    .spi_miso_o (spi_miso),
    .sdio_o     (sdio_o),
    .sdio_oe_o  (sdio_oe_o),
    .sdio_i     (sdio_i),
    .spi_dir_o  (spi_dir_o)
  );

  // Chip-select bit order follows the cs_sel_e index
  assign spi_csn_clk_o = spi_csn[0];
  assign spi_csn_dac_o = spi_csn[1];
  assign spi_csn_adc_o = spi_csn[2];

  // Status order, MSB first: trigger, fast detects, DAC irq, clock status, switches
  gpio_bank #(
    .SYNC_STAGES (SYNC_STAGES)
  ) gpio_bank_i (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .wr_i        (gpio_wr_i),
    .wdata_i     (gpio_wdata_i),
    .ctrl_o      (gpio_ctrl_o),
    .stat_i      ({trig_i, adc_fdb_i, adc_fda_i, dac_irq_i, clkd_status_i, gpio_bd_i}),
    .stat_o      (gpio_stat_o),
    .adc_pd_o    (adc_pd_o),
    .dac_txen_o  (dac_txen_o),
    .dac_reset_o (dac_reset_o),
    .clkd_sync_o (clkd_sync_o),
    .led_o       (gpio_bd_o)
  );

endmodule

`default_nettype wire

// File: verilog/gpio_bank.sv
/*
 * GPIO bank for the converter board.
 * A control register drives the converter pins and LEDs and reads
 * back as a whole. Status inputs pass through a synchronizer.
 */

`default_nettype none

module gpio_bank import daq_pkg::*; #(
  parameter int SYNC_STAGES = 2
) (
  input  wire logic                   clk_i,
  input  wire logic                   rst_n_i,
  input  wire logic                   wr_i,
  input  wire logic [GPIO_CTRL_W-1:0] wdata_i,
  output logic      [GPIO_CTRL_W-1:0] ctrl_o,
  input  wire logic [GPIO_STAT_W-1:0] stat_i,
  output logic      [GPIO_STAT_W-1:0] stat_o,
  output logic                        adc_pd_o,
  output logic                        dac_txen_o,
  output logic                        dac_reset_o,
  output logic                        clkd_sync_o,
  output logic      [GPIO_LED_W-1:0]  led_o
);

  logic [GPIO_CTRL_W-1:0] ctrl_q;
  logic [GPIO_STAT_W-1:0] sync_q [SYNC_STAGES];

  // ****************************************
  // Control register
  // ****************************************

  // Zero after reset: ADC powered up, DAC off and out of reset
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ctrl_q <= '0;
    end else if (wr_i) begin
      ctrl_q <= wdata_i;
    end
  end

  // Readback of the whole register, unused bits included
  assign ctrl_o = ctrl_q;

  assign adc_pd_o    = ctrl_q[GPIO_ADC_PD];
  assign dac_txen_o  = ctrl_q[GPIO_DAC_TXEN];
  assign dac_reset_o = ctrl_q[GPIO_DAC_RESET];
  assign clkd_sync_o = ctrl_q[GPIO_CLKD_SYNC];
  assign led_o       = ctrl_q[GPIO_LED_W-1:0];

  // ****************************************
  // Status synchronizer
  // ****************************************

  // Board pins are asynchronous to clk_i, every bit gets the same depth
  always_ff @(posedge clk_i) begin
    sync_q[0] <= stat_i;
    for (int i = 1; i < SYNC_STAGES; i++) begin
      sync_q[i] <= sync_q[i-1];
    end
  end

  assign stat_o = sync_q[SYNC_STAGES-1];

endmodule

`default_nettype wire

// File: verilog/spi_3wire_bridge.sv
/*
 * Three-wire SPI adapter.
 * Puts MOSI and MISO on one data line. It decodes the read bit
 * from the bus itself and releases the line to the device after
 * the instruction phase of a read.
 */

`default_nettype none

module spi_3wire_bridge import daq_pkg::*; (
  input  wire logic                clk_i,
  input  wire logic                rst_n_i,
  input  wire logic [SPI_CS_W-1:0] spi_csn_i,
  input  wire logic                spi_sclk_i,
  input  wire logic                spi_mosi_i,
  output logic                     spi_miso_o,
  output logic                     sdio_o,
  output logic                     sdio_oe_o,
  input  wire logic                sdio_i,
  output logic                     spi_dir_o
);

  // Counter only has to reach the end of the instruction phase
  localparam int CNT_W = $clog2(SPI_INSTR_W + 1);

  logic             sclk_d;
  logic [CNT_W-1:0] cnt_q;
  logic             rd_q;
  logic             dir_q;

  logic active;
  logic sclk_rise;
  logic drive;

  // Any chip select low means a transaction is running
  assign active    = ~&spi_csn_i;
  assign sclk_rise = spi_sclk_i && !sclk_d;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      sclk_d <= 1'b0;
      cnt_q  <= '0;
      rd_q   <= 1'b0;
      dir_q  <= 1'b1;
    end else begin
      sclk_d <= spi_sclk_i;
      if (!active) begin
        // Rearm for the next transaction
        cnt_q <= '0;
        rd_q  <= 1'b0;
        dir_q <= 1'b1;
      end else if (sclk_rise) begin
        // The read bit is on MOSI at the first rising edge
        if (cnt_q == '0) begin
          rd_q <= spi_mosi_i;
        end
        if (cnt_q < CNT_W'(SPI_INSTR_W)) begin
          cnt_q <= cnt_q + 1'b1;
        end
        // The device owns the line after the last instruction edge of a read
        if ((cnt_q == CNT_W'(SPI_INSTR_W - 1)) && rd_q) begin
          dir_q <= 1'b0;
        end
      end
    end
  end

  // Drive comes back as soon as every chip select is high
  assign drive = dir_q || !active;

  assign sdio_o     = spi_mosi_i;
  assign sdio_oe_o  = drive;
  assign spi_dir_o  = drive;
  assign spi_miso_o = drive ? 1'b0 : sdio_i;

endmodule

`default_nettype wire

// File: verilog/spi_master.sv
/*
 * SPI master for 24-bit register transactions.
 * Shifts the read bit, address and data out MSB first on one of
 * three chip selects and captures the returned byte on reads.
 * SCLK idles low, data changes on falling edges.
 */

`default_nettype none

module spi_master import daq_pkg::*; #(
  parameter int SCLK_DIV = 4
) (
  input  wire logic                  clk_i,
  input  wire logic                  rst_n_i,
  input  wire logic                  start_i,
  input  wire cs_sel_e               cs_i,
  input  wire logic                  read_i,
  input  wire logic [SPI_ADDR_W-1:0] addr_i,
  input  wire logic [SPI_DATA_W-1:0] wdata_i,
  output logic                       busy_o,
  output logic                       done_o,
  output logic      [SPI_DATA_W-1:0] rdata_o,
  output logic      [SPI_CS_W-1:0]   spi_csn_o,
  output logic                       spi_sclk_o,
  output logic                       spi_mosi_o,
  input  wire logic                  spi_miso_i
);

  // A divider of one still needs a one-bit counter
  localparam int DIV_W = (SCLK_DIV > 1) ? $clog2(SCLK_DIV) : 1;
  localparam int BIT_W = $clog2(SPI_WORD_W);

  spi_state_e            state_q;
  logic [DIV_W-1:0]      div_q;
  logic [BIT_W-1:0]      bit_q;
  logic                  sclk_q;
  logic [SPI_CS_W-1:0]   csn_q;
  logic [SPI_WORD_W-1:0] tx_q;
  logic [SPI_DATA_W-1:0] rx_q;
  logic                  read_q;

  logic accept;
  logic half_end;
  logic last_bit;
  logic rise_e;
  logic fall_e;

  // Starts are only taken from idle, anything else is dropped
  assign accept   = (state_q == SPI_IDLE) && start_i;
  assign half_end = (div_q == DIV_W'(SCLK_DIV - 1));
  assign last_bit = (bit_q == BIT_W'(SPI_WORD_W - 1));
  // The setup cycle ends with the first rising edge
  assign rise_e = (state_q == SPI_SETUP) ||
                  ((state_q == SPI_SHIFT) && half_end && !sclk_q);
  assign fall_e = (state_q == SPI_SHIFT) && half_end && sclk_q;

  // ****************************************
  // Sequencer
  // ****************************************

  // Setup 1 + shift 47 half-periods + hold 1 half-period + done 1 cycle
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= SPI_IDLE;
      div_q   <= '0;
      bit_q   <= '0;
      sclk_q  <= 1'b0;
      csn_q   <= '1;
      done_o  <= 1'b0;
    end else begin
      done_o <= 1'b0;
      case (state_q)
        SPI_IDLE: begin
          if (start_i) begin
            // Exactly one chip select goes low, chosen by the enum index
            csn_q   <= ~(SPI_CS_W'(1) << cs_i);
            div_q   <= '0;
            bit_q   <= '0;
            state_q <= SPI_SETUP;
          end
        end
        SPI_SETUP: begin
          // First bit has had one cycle of setup, raise the clock
          sclk_q  <= 1'b1;
          state_q <= SPI_SHIFT;
        end
        SPI_SHIFT: begin
          if (half_end) begin
            div_q  <= '0;
            sclk_q <= !sclk_q;
            if (sclk_q) begin
              // The last falling edge leads into the hold half-period
              if (last_bit) begin
                state_q <= SPI_HOLD;
              end else begin
                bit_q <= bit_q + 1'b1;
              end
            end
          end else begin
            div_q <= div_q + 1'b1;
          end
        end
        SPI_HOLD: begin
          if (half_end) begin
            div_q   <= '0;
            csn_q   <= '1;
            state_q <= SPI_DONE;
          end else begin
            div_q <= div_q + 1'b1;
          end
        end
        SPI_DONE: begin
          done_o  <= 1'b1;
          state_q <= SPI_IDLE;
        end
        default: state_q <= SPI_IDLE;
      endcase
    end
  end

  // ****************************************
  // Data path
  // ****************************************

  always_ff @(posedge clk_i) begin
    if (accept) begin
      tx_q    <= {read_i, addr_i, wdata_i};
      read_q  <= read_i;
      rdata_o <= '0;
    end
    if (fall_e && !last_bit) begin
      tx_q <= tx_q << 1;
    end
    // MISO is sampled on rising edges of the data phase only
    if (rise_e && (bit_q >= BIT_W'(SPI_INSTR_W))) begin
      rx_q <= {rx_q[SPI_DATA_W-2:0], spi_miso_i};
    end
    // Writes return zero so the readback stays defined
    if (state_q == SPI_DONE) begin
      rdata_o <= read_q ? rx_q : '0;
    end
  end

  assign busy_o     = (state_q != SPI_IDLE);
  assign spi_csn_o  = csn_q;
  assign spi_sclk_o = sclk_q;
  assign spi_mosi_o = tx_q[SPI_WORD_W-1];

endmodule

`default_nettype wire

// File: verilog/daq_pkg.sv
/*
 * Shared definitions for the converter board control logic.
 * Holds the SPI instruction layout, the chip-select encoding,
 * the SPI master states and the GPIO bit map.
 */

`default_nettype none

package daq_pkg;

  // ****************************************
  // SPI instruction layout
  // ****************************************

  // One read bit, then the register address, then the data byte
  localparam int SPI_ADDR_W  = 15;
  localparam int SPI_DATA_W  = 8;
  localparam int SPI_WORD_W  = 1 + SPI_ADDR_W + SPI_DATA_W;
  // Bits driven by the FPGA before a read hands the line to the device
  localparam int SPI_INSTR_W = 1 + SPI_ADDR_W;
  localparam int SPI_CS_W    = 3;

  // Index selects the chip-select bit: 0 clock chip, 1 DAC, 2 ADC
  typedef enum logic [1:0] {
    CS_CLK = 2'd0,
    CS_DAC = 2'd1,
    CS_ADC = 2'd2
  } cs_sel_e;

  typedef enum logic [2:0] {
    SPI_IDLE,
    SPI_SETUP,
    SPI_SHIFT,
    SPI_HOLD,
    SPI_DONE
  } spi_state_e;

  // ****************************************
  // GPIO map
  // ****************************************

  // LEDs sit in the low byte, the converter control pins above them
  localparam int GPIO_LED_W     = 8;
  localparam int GPIO_CTRL_W    = GPIO_LED_W + 4;
  localparam int GPIO_CLKD_SYNC = 8;
  localparam int GPIO_DAC_RESET = 9;
  localparam int GPIO_DAC_TXEN  = 10;
  localparam int GPIO_ADC_PD    = 11;

  // Status is {trig, adc_fdb, adc_fda, dac_irq, clkd_status[1:0], board[12:0]}
  localparam int GPIO_BD_W      = 13;
  localparam int GPIO_STAT_W    = GPIO_BD_W + 6;

endpackage

`default_nettype wire
